// ==== common/vec_config.svh ====
`ifndef VEC_CONFIG_SVH
`define VEC_CONFIG_SVH

// datapath widths
`define VEC_DATA_WIDTH      16
`define VEC_GAIN_WIDTH      8
`define VEC_SHIFT_WIDTH     4

// array geometry
`define VEC_LANES           4
`define VEC_FIFO_DEPTH      16

// register map, gains sit at 0 .. VEC_LANES-1
`define VEC_CFG_ADDR_WIDTH  3
`define VEC_ADDR_SHIFT      4
`define VEC_ADDR_ENABLE     5

`endif

// ==== common/vec_pkg.sv ====
`include "vec_config.svh"

package vec_pkg;

    // one lane sample, two's complement
    typedef logic signed [`VEC_DATA_WIDTH-1:0] sample_t;

    // per-lane gain, signed
    typedef logic signed [`VEC_GAIN_WIDTH-1:0] gain_t;

    // arithmetic right shift applied after the multiply
    typedef logic [`VEC_SHIFT_WIDTH-1:0] shift_t;

    // full product, wide enough for -max * -max
    typedef logic signed [`VEC_DATA_WIDTH+`VEC_GAIN_WIDTH-1:0] product_t;

    // clamp limits for the scaler output
    localparam sample_t SAMPLE_MAX = {1'b0, {(`VEC_DATA_WIDTH-1){1'b1}}};
    localparam sample_t SAMPLE_MIN = {1'b1, {(`VEC_DATA_WIDTH-1){1'b0}}};

    // unity gain, loaded on reset
    localparam gain_t GAIN_ONE = gain_t'(1);

endpackage

// ==== design/gain_regs.sv ====
`timescale 1ns/10ps
`include "vec_config.svh"

module gain_regs import vec_pkg::*; (
    input  logic                           clock,
    input  logic                           rst,

    input  logic                           cfg_wr,
    input  logic [`VEC_CFG_ADDR_WIDTH-1:0] cfg_addr,
    input  logic [15:0]                    cfg_wdata,

    output gain_t                          gains [`VEC_LANES-1:0],
    output shift_t                         shift,
    output logic                           enable
);

    localparam int LANES = `VEC_LANES;
    localparam int AW    = `VEC_CFG_ADDR_WIDTH;

    // fixed register addresses
    localparam logic [AW-1:0] ADDR_SHIFT  = AW'(`VEC_ADDR_SHIFT);
    localparam logic [AW-1:0] ADDR_ENABLE = AW'(`VEC_ADDR_ENABLE);

    always_ff @(posedge clock) begin
        if (rst) begin
            // unity gain, no shift, scaler stopped
            for (int i = 0; i < LANES; i++) begin
                gains[i] <= GAIN_ONE;
            end
            shift  <= '0;
            enable <= 1'b0;
        end else if (cfg_wr) begin
            // gain slots map one to one onto lanes
            for (int i = 0; i < LANES; i++) begin
                if (cfg_addr == AW'(i)) begin
                    gains[i] <= gain_t'(cfg_wdata[`VEC_GAIN_WIDTH-1:0]);
                end
            end
            if (cfg_addr == ADDR_SHIFT) begin
                shift <= cfg_wdata[`VEC_SHIFT_WIDTH-1:0];
            end
            if (cfg_addr == ADDR_ENABLE) begin
                enable <= cfg_wdata[0];
            end
            // anything else falls through untouched
        end
    end

endmodule

// ==== design/lane_scaler.sv ====
`timescale 1ns/10ps
`include "vec_config.svh"

module lane_scaler import vec_pkg::*; (
    input  logic    clock,
    input  logic    rst,

    // configuration
    input  gain_t   gains [`VEC_LANES-1:0],
    input  shift_t  shift,
    input  logic    enable,

    // fifo array side
    input  logic    fifo_empty,
    input  sample_t fifo_dout [`VEC_LANES-1:0],
    output logic    rd_en,

    // scaled vector out
    output logic    out_valid,
    output sample_t out_data [`VEC_LANES-1:0]
);

    localparam int LANES = `VEC_LANES;

    // marks fifo_dout as a fresh vector
    logic data_valid;

    // per-lane datapath
    product_t prod   [LANES-1:0];
    product_t scaled [LANES-1:0];
    sample_t  sat    [LANES-1:0];

    // pull one vector per cycle while running
    assign rd_en = enable && !fifo_empty;

    // read issued at t, data on fifo_dout at t+1
    always_ff @(posedge clock) begin
        if (rst) begin
            data_valid <= 1'b0;
            out_valid  <= 1'b0;
        end else begin
            data_valid <= rd_en;
            out_valid  <= data_valid;
        end
    end

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            // full width signed multiply
            prod[i] = product_t'(fifo_dout[i]) * product_t'(gains[i]);
            // arithmetic, sign fills from the top
            scaled[i] = prod[i] >>> shift;
            // clamp to the sample range
            if (scaled[i] > product_t'(SAMPLE_MAX)) begin
                sat[i] = SAMPLE_MAX;
            end else if (scaled[i] < product_t'(SAMPLE_MIN)) begin
                sat[i] = SAMPLE_MIN;
            end else begin
                sat[i] = sample_t'(scaled[i]);
            end
        end
    end

    // result register, captured with the valid stage
    always_ff @(posedge clock) begin
        if (data_valid) begin
            for (int i = 0; i < LANES; i++) begin
                out_data[i] <= sat[i];
            end
        end
    end

    // never read from an empty array
    a_no_empty_read : assert property (@(posedge clock) disable iff (rst)
        $rose(rd_en) |-> !fifo_empty);

endmodule

// ==== design/vector_scale_top.sv ====
`timescale 1ns/10ps
`include "vec_config.svh"

module vector_scale_top import vec_pkg::*; (
    input  logic                           clock,
    input  logic                           rst,

    // sample input
    input  logic                           in_valid,
    input  sample_t                        in_data [`VEC_LANES-1:0],
    output logic                           in_full,

    // register writes
    input  logic                           cfg_wr,
    input  logic [`VEC_CFG_ADDR_WIDTH-1:0] cfg_addr,
    input  logic [15:0]                    cfg_wdata,

    // scaled output
    output logic                           out_valid,
    output sample_t                        out_data [`VEC_LANES-1:0]
);

    // array to scaler
    sample_t fifo_dout [`VEC_LANES-1:0];
    logic    fifo_empty;
    logic    rd_en;

    // registers to scaler
    gain_t   gains [`VEC_LANES-1:0];
    shift_t  shift;
    logic    enable;

    // writes while full are dropped inside the fifos
    fifo_array u_fifo_array (
        .clock (clock),
        .rst   (rst),
        .wr_en (in_valid),
        .din   (in_data),
        .full  (in_full),
        .rd_en (rd_en),
        .dout  (fifo_dout),
        .empty (fifo_empty)
    );

    gain_regs u_gain_regs (
        .clock     (clock),
        .rst       (rst),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .gains     (gains),
        .shift     (shift),
        .enable    (enable)
    );

    lane_scaler u_lane_scaler (
        .clock      (clock),
        .rst        (rst),
        .gains      (gains),
        .shift      (shift),
        .enable     (enable),
        .fifo_empty (fifo_empty),
        .fifo_dout  (fifo_dout),
        .rd_en      (rd_en),
        .out_valid  (out_valid),
        .out_data   (out_data)
    );

endmodule

// ==== fifo/fifo.sv ====
`timescale 1ns/10ps
`include "vec_config.svh"

module fifo import vec_pkg::*; (
    input  logic    clock,
    input  logic    rst,

    input  logic    wr_en,
    input  sample_t din,
    output logic    full,

    input  logic    rd_en,
    output sample_t dout,
    output logic    empty
);

    localparam int DEPTH = `VEC_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    // circular buffer storage
    sample_t mem [DEPTH-1:0];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // strobes that actually move data
    logic wr_ok;
    logic rd_ok;

    assign wr_ok = wr_en && !full;
    assign rd_ok = rd_en && !empty;

    // flags straight off the occupancy register
    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    // pointers and occupancy
    always_ff @(posedge clock) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) begin
                // explicit wrap covers a depth that is not a power of two
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // buffer write
    always_ff @(posedge clock) begin
        if (wr_ok) begin
            mem[wr_ptr] <= din;
        end
    end

    // registered read data held between reads
    always_ff @(posedge clock) begin
        if (rd_ok) begin
            dout <= mem[rd_ptr];
        end
    end

    // occupancy stays within the buffer
    a_count_bound : assert property (@(posedge clock) disable iff (rst)
        count <= CNT_W'(DEPTH));

    // output only moves one cycle after a read that was taken
    a_dout_hold : assert property (@(posedge clock) disable iff (rst)
        !$past(rd_ok) |-> $stable(dout));

endmodule

// ==== fifo/fifo_array.sv ====
`timescale 1ns/10ps
`include "vec_config.svh"

module fifo_array import vec_pkg::*; (
    input  logic    clock,
    input  logic    rst,

    input  logic    wr_en,
    input  sample_t din [`VEC_LANES-1:0],
    output logic    full,

    input  logic    rd_en,
    output sample_t dout [`VEC_LANES-1:0],
    output logic    empty
);

    localparam int LANES = `VEC_LANES;

    // per-lane status
    logic [LANES-1:0] full_arr;
    logic [LANES-1:0] empty_arr;

    // one fifo per lane, all strobed together
    genvar i;
    generate
        for (i = 0; i < LANES; i = i + 1) begin : g_lane
            fifo u_fifo (
                .clock (clock),
                .rst   (rst),

                .wr_en (wr_en),
                .din   (din[i]),
                .full  (full_arr[i]),

                .rd_en (rd_en),
                .dout  (dout[i]),
                .empty (empty_arr[i])
            );
        end
    endgenerate

    // any lane full or empty blocks the whole vector
    assign full  = |full_arr;
    assign empty = |empty_arr;

    // lanes move in lock step, so their occupancy never diverges
    a_lanes_agree : assert property (@(posedge clock) disable iff (rst)
        (&empty_arr) == (|empty_arr));

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the vector scaler simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f \
    --top-module tb_vector_scale \
    -o sim_vector_scale

out=$(./obj_dir/sim_vector_scale)
echo "$out"

# pass only when the testbench printed its pass line
echo "$out" | grep -qx "TEST OK" || exit 1

// ==== sim/tb_vector_scale.sv ====
`timescale 1ns/10ps
`include "vec_config.svh"

module tb_vector_scale import vec_pkg::*; ;

    localparam int LANES      = `VEC_LANES;
    localparam int DEPTH      = `VEC_FIFO_DEPTH;
    localparam int MAX_CYCLES = 3000;
    // clamp limits worked out from the sample width
    localparam int LIM_MAX    = (1 << (`VEC_DATA_WIDTH - 1)) - 1;
    localparam int LIM_MIN    = -(1 << (`VEC_DATA_WIDTH - 1));

    logic                           clock;
    logic                           rst;
    logic                           in_valid;
    sample_t                        in_data [LANES-1:0];
    logic                           in_full;
    logic                           cfg_wr;
    logic [`VEC_CFG_ADDR_WIDTH-1:0] cfg_addr;
    logic [15:0]                    cfg_wdata;
    logic                           out_valid;
    sample_t                        out_data [LANES-1:0];

    // register model, mirrors every write the testbench makes
    gain_t   gain_m [LANES-1:0];
    shift_t  shift_m;

    sample_t     stim_vec [LANES-1:0];
    sample_t     exp_q [$];
    logic [31:0] lfsr_state;
    int          errors;
    int          checks;
    int          accepted;
    int          dropped;
    int          outputs;
    int          cycle_count;
    int          acc_mark;
    int          out_mark;

    vector_scale_top uut (
        .clock     (clock),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_full   (in_full),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // multiply, arithmetic shift, clamp to the sample range
    function automatic sample_t scale_ref(input sample_t s, input gain_t g, input shift_t sh);
        int p;
        int q;
        p = int'(s) * int'(g);
        q = p >>> sh;
        if (q > LIM_MAX) q = LIM_MAX;
        if (q < LIM_MIN) q = LIM_MIN;
        return sample_t'(q);
    endfunction

    task automatic report_error(input string msg);
        $display("ERROR time=%0t: %s", $time, msg);
        errors++;
    endtask

    task automatic check_sample(input string name, input sample_t exp, input sample_t act);
        checks++;
        if (act !== exp) begin
            $display("MISMATCH time=%0t %s expected=%0d actual=%0d", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            $display("MISMATCH time=%0t %s expected=%0b actual=%0b", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic print_summary();
        $display("summary: checks=%0d errors=%0d accepted=%0d dropped=%0d outputs=%0d",
                 checks, errors, accepted, dropped, outputs);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clock);
            in_valid = 1'b0;
            cfg_wr   = 1'b0;
        end
    endtask

    // strobe stays up until the next task drives its own edge
    task automatic cfg_write(input int addr, input logic [15:0] data);
        @(negedge clock);
        in_valid  = 1'b0;
        cfg_wr    = 1'b1;
        cfg_addr  = addr[`VEC_CFG_ADDR_WIDTH-1:0];
        cfg_wdata = data;
        if (addr < LANES) gain_m[addr] = gain_t'(data[`VEC_GAIN_WIDTH-1:0]);
        if (addr == `VEC_ADDR_SHIFT) shift_m = shift_t'(data[`VEC_SHIFT_WIDTH-1:0]);
    endtask

    // in_full here is the flag the next rising edge sees
    task automatic send_vector();
        @(negedge clock);
        cfg_wr   = 1'b0;
        in_valid = 1'b1;
        for (int i = 0; i < LANES; i++) in_data[i] = stim_vec[i];
        if (!in_full) begin
            for (int i = 0; i < LANES; i++) begin
                exp_q.push_back(scale_ref(stim_vec[i], gain_m[i], shift_m));
            end
            accepted++;
        end else begin
            dropped++;
        end
    endtask

    task automatic send_random_vector();
        for (int i = 0; i < LANES; i++) stim_vec[i] = sample_t'(rand_bits(16));
        send_vector();
    endtask

    task automatic send_fill(input sample_t val);
        for (int i = 0; i < LANES; i++) stim_vec[i] = val;
        send_vector();
    endtask

    // scaler must be enabled, else this only ends on the watchdog
    task automatic wait_drained();
        idle(1);
        while (exp_q.size() != 0) @(negedge clock);
        idle(2);
    endtask

    // scoreboard, outputs are registered so the falling edge sees them settled
    always @(negedge clock) begin
        if (!rst && out_valid) begin
            outputs++;
            if (exp_q.size() < LANES) begin
                report_error("output vector arrived with no accepted vector waiting");
            end else begin
                for (int i = 0; i < LANES; i++) begin
                    check_sample($sformatf("out_data[%0d]", i), exp_q.pop_front(), out_data[i]);
                end
            end
        end
    end

    // watchdog
    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, outputs stopped arriving", cycle_count);
            print_summary();
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        in_valid = 1'b0;
        cfg_wr = 1'b0;
        cfg_addr = '0;
        cfg_wdata = '0;
        for (int i = 0; i < LANES; i++) begin
            in_data[i] = '0;
            gain_m[i] = gain_t'(1);
        end
        shift_m = '0;
        lfsr_state = 32'h3f93;
        errors = 0;
        checks = 0;
        accepted = 0;
        dropped = 0;
        outputs = 0;
        cycle_count = 0;
        repeat (5) @(negedge clock);
        rst = 1'b0;

        // reset defaults, then unity gain pass-through
        repeat (4) begin
            @(negedge clock);
            check_flag("out_valid", 1'b0, out_valid);
            check_flag("in_full", 1'b0, in_full);
        end
        cfg_write(`VEC_ADDR_ENABLE, 16'h0001);
        repeat (10) send_random_vector();
        wait_drained();

        // random gains and shift per burst
        repeat (10) begin
            for (int i = 0; i < LANES; i++) cfg_write(i, 16'(rand_bits(8)));
            cfg_write(`VEC_ADDR_SHIFT, 16'(rand_bits(4)));
            repeat (20) send_random_vector();
            wait_drained();
        end

        // large gains of both signs against the extremes
        cfg_write(0, 16'h007f);
        cfg_write(1, 16'h0080);
        cfg_write(2, 16'h0002);
        cfg_write(3, 16'h007f);
        cfg_write(`VEC_ADDR_SHIFT, 16'h0000);
        send_fill(SAMPLE_MAX);
        send_fill(SAMPLE_MIN);
        send_fill(sample_t'(100));
        send_fill(sample_t'(-300));
        wait_drained();

        // stall reads, fill the array, extra vectors dropped
        cfg_write(`VEC_ADDR_ENABLE, 16'h0000);
        acc_mark = accepted;
        out_mark = outputs;
        repeat (DEPTH) send_random_vector();
        idle(1);
        check_flag("in_full", 1'b1, in_full);
        repeat (4) send_random_vector();
        idle(1);
        if (accepted - acc_mark != DEPTH) report_error("fill phase accepted a wrong vector count");
        cfg_write(`VEC_ADDR_ENABLE, 16'h0001);
        wait_drained();
        if (outputs - out_mark != DEPTH) report_error("fill phase drained a wrong vector count");

        // enable toggled at random inside a stream
        repeat (120) begin
            if (rand_bits(3) == 0) cfg_write(`VEC_ADDR_ENABLE, 16'(rand_bits(1)));
            send_random_vector();
        end
        cfg_write(`VEC_ADDR_ENABLE, 16'h0001);
        wait_drained();

        // unused addresses must leave every register alone
        cfg_write(6, 16'hffff);
        cfg_write(7, 16'h0000);
        repeat (20) send_random_vector();
        wait_drained();

        idle(4);
        if (outputs != accepted) report_error("output count differs from accepted count");
        print_summary();
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+common
common/vec_pkg.sv
fifo/fifo.sv
fifo/fifo_array.sv
design/gain_regs.sv
design/lane_scaler.sv
design/vector_scale_top.sv
sim/tb_vector_scale.sv
